// File: logic/mem_dm_pkg.sv
// Data mover formats
`default_nettype none

package mem_dm_pkg;

   localparam int ADDR_WIDTH   = 32;                     // Memory address
   localparam int BTT_WIDTH    = 23;                     // Bytes to transfer
   localparam int DATA_WIDTH   = 512;                    // Stream data
   localparam int KEEP_WIDTH   = DATA_WIDTH / 8;         // One keep bit per byte
   localparam int DM_CMD_WIDTH = 72;                     // Full command word

   // User side memory command
   typedef struct packed {
      logic [ADDR_WIDTH-1:0] address;                    // Start address
      logic [BTT_WIDTH-1:0]  length;                     // Transfer length in bytes
   } mem_cmd_t;

   // Data mover command word, MSB first
   typedef struct packed {
      logic [DM_CMD_WIDTH-ADDR_WIDTH-BTT_WIDTH-14:0] reserved; // Pads word to 72 bits
      logic [3:0]            tag;                        // Echoed back in status
      logic [ADDR_WIDTH-1:0] address;                    // Start address
      logic                  drr;                        // Realignment request
      logic                  eof;                        // End of frame
      logic [5:0]            dsa;                        // Destination start offset
      logic                  cmd_type;                   // Incrementing burst when set
      logic [BTT_WIDTH-1:0]  btt;                        // Bytes to transfer
   } dm_cmd_t;

   typedef struct packed {
      logic       okay;                                  // Bit 7, clear on any error
      logic       slverr;                                // Slave error
      logic       decerr;                                // Decode error
      logic       interr;                                // Internal error
      logic [3:0] tag;                                   // Tag of finished command
   } dm_status_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic [KEEP_WIDTH-1:0] keep;                       // Byte enables
      logic                  last;                       // Final beat of packet
   } axis_beat_t;

endpackage

`default_nettype wire

// File: logic/mem_stats_pkg.sv
// Channel statistics types
`default_nettype none

package mem_stats_pkg;

   localparam int COUNT_WIDTH  = 32;                     // Event counters
   localparam int LENGTH_WIDTH = 48;                     // Byte counter
   localparam int BYTE_GRAIN   = 8;                      // Keep step in bytes

   // Per stream metering
   typedef struct packed {
      logic [COUNT_WIDTH-1:0]  words;                    // Accepted beats
      logic [COUNT_WIDTH-1:0]  packets;                  // Beats with last
      logic [LENGTH_WIDTH-1:0] bytes;                    // Bytes of regular masks
   } stream_stats_t;

   // Per direction status counts
   typedef struct packed {
      logic [COUNT_WIDTH-1:0] statuses;                  // All status bytes
      logic [COUNT_WIDTH-1:0] errors;                    // Status with okay clear
   } status_stats_t;

endpackage

`default_nettype wire

// File: logic/mem_cmd_format.sv
// Command word packer
`timescale 1ns/1ns
`default_nettype none

module mem_cmd_format
   import mem_dm_pkg::*, mem_stats_pkg::*;
(
   input  logic                   mem_clk,
   input  logic                   mem_aresetn,
   input  mem_cmd_t               cmd,                   // From user
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   output dm_cmd_t                dm_cmd,                // To data mover
   output logic                   dm_cmd_valid,
   input  logic                   dm_cmd_ready,
   output logic [COUNT_WIDTH-1:0] cmd_count              // Accepted commands
);

   logic    accept;                                      // User handshake
   dm_cmd_t packed_cmd;                                  // Next entry contents

   // Room when empty or draining this cycle
   assign cmd_ready = ~dm_cmd_valid | dm_cmd_ready;
   assign accept    = cmd_valid & cmd_ready;

   always_comb begin
      packed_cmd          = '0;                          // Reserved, tag, dsa at zero
      packed_cmd.address  = cmd.address;
      packed_cmd.drr      = 1'b1;
      packed_cmd.eof      = 1'b1;
      packed_cmd.cmd_type = 1'b1;                        // Incrementing
      packed_cmd.btt      = cmd.length[BTT_WIDTH-1:0];
   end

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         dm_cmd_valid <= 1'b0;
         cmd_count    <= '0;
      end else begin
         if (accept) begin
            dm_cmd_valid <= 1'b1;                        // Refill, also on drain
            cmd_count    <= cmd_count + 1'b1;
         end else if (dm_cmd_ready) begin
            dm_cmd_valid <= 1'b0;                        // Entry taken, none new
         end
      end
   end

   always_ff @(posedge mem_clk) begin
      if (accept) begin
         dm_cmd <= packed_cmd;                           // One cycle to output
      end
   end

   // Entry must not change while the data mover stalls
   a_dm_cmd_hold: assert property (
      @(posedge mem_clk) disable iff (!mem_aresetn)
      dm_cmd_valid && !dm_cmd_ready |=> dm_cmd_valid && $stable(dm_cmd)
   );

endmodule

`default_nettype wire

// File: logic/mem_beat_meter.sv
// Stream beat meter
`timescale 1ns/1ns
`default_nettype none

module mem_beat_meter
   import mem_dm_pkg::*, mem_stats_pkg::*;
(
   input  logic          mem_clk,
   input  logic          mem_aresetn,
   input  axis_beat_t    beat,                           // Observed beat
   input  logic          beat_valid,
   input  logic          beat_ready,
   output stream_stats_t stats                           // Running counts
);

   localparam int GROUPS = KEEP_WIDTH / BYTE_GRAIN;      // Masks of 8k bytes

   logic                    handshake;
   logic [LENGTH_WIDTH-1:0] beat_bytes;                  // Bytes this beat adds

   assign handshake = beat_valid & beat_ready;

   // Only contiguous low masks of whole groups count
   always_comb begin
      logic [KEEP_WIDTH-1:0] low_mask;
      beat_bytes = '0;                                   // Irregular masks add nothing
      for (int k = 1; k <= GROUPS; k++) begin
         low_mask = {KEEP_WIDTH{1'b1}} >> (KEEP_WIDTH - k * BYTE_GRAIN);
         if (beat.keep == low_mask) begin
            beat_bytes = LENGTH_WIDTH'(k * BYTE_GRAIN);
         end
      end
   end

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         stats <= '0;
      end else if (handshake) begin
         stats.words <= stats.words + 1'b1;
         if (beat.last) begin
            stats.packets <= stats.packets + 1'b1;       // Packet ends here
         end
         stats.bytes <= stats.bytes + beat_bytes;
      end
   end

   // A beat always carries at least one byte
   a_keep_nonzero: assert property (
      @(posedge mem_clk) disable iff (!mem_aresetn)
      beat_valid |-> beat.keep != '0
   );

endmodule

`default_nettype wire

// File: logic/mem_status_tracker.sv
// Status counter
`timescale 1ns/1ns
`default_nettype none

module mem_status_tracker
   import mem_dm_pkg::*, mem_stats_pkg::*;
(
   input  logic          mem_clk,
   input  logic          mem_aresetn,
   input  dm_status_t    status,                         // Observed status byte
   input  logic          status_valid,
   input  logic          status_ready,
   output status_stats_t stats
);

   logic handshake;

   assign handshake = status_valid & status_ready;

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         stats <= '0;
      end else if (handshake) begin
         stats.statuses <= stats.statuses + 1'b1;
         if (!status.okay) begin
            stats.errors <= stats.errors + 1'b1;         // Any failed transfer
         end
      end
   end

   // Data mover must present a defined status byte
   a_status_known: assert property (
      @(posedge mem_clk) disable iff (!mem_aresetn)
      status_valid |-> !$isunknown(status)
   );

endmodule

`default_nettype wire

// File: logic/mem_channel_monitor.sv
// Memory channel front end
`timescale 1ns/1ns
`default_nettype none

module mem_channel_monitor
   import mem_dm_pkg::*, mem_stats_pkg::*;
(
   input  logic                   mem_clk,
   input  logic                   mem_aresetn,
   // User commands
   input  mem_cmd_t               read_cmd,
   input  logic                   read_cmd_valid,
   output logic                   read_cmd_ready,
   input  mem_cmd_t               write_cmd,
   input  logic                   write_cmd_valid,
   output logic                   write_cmd_ready,
   // User data
   input  axis_beat_t             write_data,
   input  logic                   write_data_valid,
   output logic                   write_data_ready,
   output axis_beat_t             read_data,
   output logic                   read_data_valid,
   input  logic                   read_data_ready,
   // User status
   output dm_status_t             read_status,
   output logic                   read_status_valid,
   input  logic                   read_status_ready,
   output dm_status_t             write_status,
   output logic                   write_status_valid,
   input  logic                   write_status_ready,
   // Data mover commands
   output dm_cmd_t                dm_read_cmd,
   output logic                   dm_read_cmd_valid,
   input  logic                   dm_read_cmd_ready,
   output dm_cmd_t                dm_write_cmd,
   output logic                   dm_write_cmd_valid,
   input  logic                   dm_write_cmd_ready,
   // Data mover streams
   output axis_beat_t             dm_write_data,
   output logic                   dm_write_data_valid,
   input  logic                   dm_write_data_ready,
   input  axis_beat_t             dm_read_data,
   input  logic                   dm_read_data_valid,
   output logic                   dm_read_data_ready,
   // Data mover status
   input  dm_status_t             dm_read_status,
   input  logic                   dm_read_status_valid,
   output logic                   dm_read_status_ready,
   input  dm_status_t             dm_write_status,
   input  logic                   dm_write_status_valid,
   output logic                   dm_write_status_ready,
   // Statistics
   output logic [COUNT_WIDTH-1:0] read_cmd_count,
   output logic [COUNT_WIDTH-1:0] write_cmd_count,
   output stream_stats_t          read_stream_stats,
   output stream_stats_t          write_stream_stats,
   output status_stats_t          read_status_stats,
   output status_stats_t          write_status_stats
);

   // Streams pass straight through, ready flows back untouched
   assign dm_write_data         = write_data;
   assign dm_write_data_valid   = write_data_valid;
   assign write_data_ready      = dm_write_data_ready;
   assign read_data             = dm_read_data;
   assign read_data_valid       = dm_read_data_valid;
   assign dm_read_data_ready    = read_data_ready;

   // Status bytes likewise
   assign read_status           = dm_read_status;
   assign read_status_valid     = dm_read_status_valid;
   assign dm_read_status_ready  = read_status_ready;
   assign write_status          = dm_write_status;
   assign write_status_valid    = dm_write_status_valid;
   assign dm_write_status_ready = write_status_ready;

   mem_cmd_format u_read_cmd (                           // Read command path
      .mem_clk, .mem_aresetn,
      .cmd(read_cmd), .cmd_valid(read_cmd_valid), .cmd_ready(read_cmd_ready),
      .dm_cmd(dm_read_cmd), .dm_cmd_valid(dm_read_cmd_valid),
      .dm_cmd_ready(dm_read_cmd_ready), .cmd_count(read_cmd_count)
   );

   mem_cmd_format u_write_cmd (                          // Write command path
      .mem_clk, .mem_aresetn,
      .cmd(write_cmd), .cmd_valid(write_cmd_valid), .cmd_ready(write_cmd_ready),
      .dm_cmd(dm_write_cmd), .dm_cmd_valid(dm_write_cmd_valid),
      .dm_cmd_ready(dm_write_cmd_ready), .cmd_count(write_cmd_count)
   );

   mem_beat_meter u_read_meter (
      .mem_clk, .mem_aresetn,
      .beat(dm_read_data), .beat_valid(dm_read_data_valid),
      .beat_ready(read_data_ready), .stats(read_stream_stats)
   );

   mem_beat_meter u_write_meter (
      .mem_clk, .mem_aresetn,
      .beat(write_data), .beat_valid(write_data_valid),
      .beat_ready(dm_write_data_ready), .stats(write_stream_stats)
   );

   mem_status_tracker u_read_status (
      .mem_clk, .mem_aresetn,
      .status(dm_read_status), .status_valid(dm_read_status_valid),
      .status_ready(read_status_ready), .stats(read_status_stats)
   );

   mem_status_tracker u_write_status (
      .mem_clk, .mem_aresetn,
      .status(dm_write_status), .status_valid(dm_write_status_valid),
      .status_ready(write_status_ready), .stats(write_status_stats)
   );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,                      // Full clock period
   parameter int RESET_CYCLES = 2                        // Edges with reset held
) (
   output logic mem_clk,
   output logic mem_aresetn
);

   initial begin
      mem_clk = 1'b0;
      forever #(PERIOD_NS / 2) mem_clk = ~mem_clk;       // Free running
   end

   initial begin
      mem_aresetn <= 1'b0;                               // Active from time zero
      repeat (RESET_CYCLES) @(posedge mem_clk);
      mem_aresetn <= 1'b1;                               // Released on a rising edge
   end

endmodule

`default_nettype wire

// File: tb/tb_mem_channel_monitor.sv
// Channel front end testbench
`timescale 1ns/1ns
`default_nettype none

module tb_mem_channel_monitor
   import mem_dm_pkg::*, mem_stats_pkg::*;
;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_BEATS  = 400;                      // Per data stream
   localparam int TIMEOUT_NS = (2 * NUM_BEATS * 4 + 200) * CLK_PERIOD;

   typedef logic [599:0] wide_t;                         // Room for any checked value

   logic mem_clk, mem_aresetn;
   mem_cmd_t read_cmd, write_cmd;
   logic read_cmd_valid, read_cmd_ready, write_cmd_valid, write_cmd_ready;
   axis_beat_t write_data, read_data, dm_write_data, dm_read_data;
   logic write_data_valid, write_data_ready, read_data_valid, read_data_ready;
   logic dm_write_data_valid, dm_write_data_ready, dm_read_data_valid, dm_read_data_ready;
   dm_status_t read_status, write_status, dm_read_status, dm_write_status;
   logic read_status_valid, read_status_ready, write_status_valid, write_status_ready;
   logic dm_read_status_valid, dm_read_status_ready;
   logic dm_write_status_valid, dm_write_status_ready;
   dm_cmd_t dm_read_cmd, dm_write_cmd;
   logic dm_read_cmd_valid, dm_read_cmd_ready, dm_write_cmd_valid, dm_write_cmd_ready;
   logic [COUNT_WIDTH-1:0] read_cmd_count, write_cmd_count;
   stream_stats_t read_stream_stats, write_stream_stats;
   status_stats_t read_status_stats, write_status_stats;

   logic [31:0]            rand_state = 32'hd22bb4c4;    // Xorshift state
   int                     error_count = 0;
   int                     read_beats = 0;
   int                     write_beats = 0;
   logic [71:0]            read_q[$], write_q[$];        // Commands owed to the data mover
   logic [71:0]            read_head, write_head;        // Oldest owed command
   int                     read_pending, write_pending;
   logic [COUNT_WIDTH-1:0] model_read_cmds, model_write_cmds;
   stream_stats_t          model_read_stream, model_write_stream;
   status_stats_t          model_read_status, model_write_status;

   tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clock_gen (.mem_clk, .mem_aresetn);

   mem_channel_monitor u_mem_channel_monitor (.*);       // Ports match by name

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rand_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rand_state = x;
      return x;
   endfunction

   // Word layout from the top: reserved, tag, address, drr, eof, dsa, type, btt
   function automatic logic [71:0] pack_expected(mem_cmd_t c);
      return {4'h0, 4'h0, c.address, 1'b1, 1'b1, 6'h00, 1'b1, c.length[22:0]};
   endfunction

   // Counts only a contiguous low run of whole 8 byte groups
   function automatic logic [LENGTH_WIDTH-1:0] regular_keep_bytes(logic [KEEP_WIDTH-1:0] keep);
      int ones;
      ones = 0;
      for (int i = 0; i < KEEP_WIDTH; i++) begin
         if (keep[i] && ones == i) ones = i + 1;         // Length of low run
      end
      if (ones != 0 && ones % 8 == 0 && (keep >> ones) == '0) return LENGTH_WIDTH'(ones);
      return '0;
   endfunction

   function automatic stream_stats_t add_beat(stream_stats_t s, axis_beat_t b);
      s.words = s.words + 1;
      if (b.last) s.packets = s.packets + 1;
      s.bytes = s.bytes + regular_keep_bytes(b.keep);
      return s;
   endfunction

   function automatic status_stats_t add_status(status_stats_t s, dm_status_t st);
      s.statuses = s.statuses + 1;
      if (!st[7]) s.errors = s.errors + 1;               // Okay bit clear
      return s;
   endfunction

   function automatic mem_cmd_t random_cmd();
      mem_cmd_t    c;
      logic [31:0] r;
      r = next_random();
      c.address = next_random();
      c.length  = r[22:0];
      return c;
   endfunction

   function automatic logic [KEEP_WIDTH-1:0] random_keep();
      logic [31:0]           r;
      int                    k;
      logic [KEEP_WIDTH-1:0] low;
      r   = next_random();
      k   = int'(r[4:2]) + 1;
      low = {KEEP_WIDTH{1'b1}} >> (KEEP_WIDTH - 8 * k); // Low 8k bytes
      if (r[1:0] == 2'd3 && r[5]) return low >> 1;      // Low run one byte short
      if (r[1:0] == 2'd3) return {next_random(), next_random()} | 64'h1;  // Scattered bits
      if (r[1:0] == 2'd2) return '1;
      return low;
   endfunction

   function automatic axis_beat_t random_beat();
      axis_beat_t b;
      for (int i = 0; i < DATA_WIDTH / 32; i++) b.data[i*32 +: 32] = next_random();
      b.keep = random_keep();
      b.last = (next_random() & 3) == 0;                 // About one beat in four
      return b;
   endfunction

   task automatic log_mismatch(string name, wide_t got, wide_t expected);
      error_count++;
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, expected);
   endtask

   task automatic flag_failure(string what);
      error_count++;
      $display("[ERROR] %0t %s", $time, what);
   endtask

   // Reference model fed from handshakes at the DUT ports
   always @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         read_q.delete();
         write_q.delete();
         model_read_cmds    <= '0;
         model_write_cmds   <= '0;
         model_read_stream  <= '0;
         model_write_stream <= '0;
         model_read_status  <= '0;
         model_write_status <= '0;
      end else begin
         if (dm_read_cmd_valid && dm_read_cmd_ready && read_q.size() != 0) begin
            void'(read_q.pop_front());                   // Taken by data mover
         end
         if (dm_write_cmd_valid && dm_write_cmd_ready && write_q.size() != 0) begin
            void'(write_q.pop_front());
         end
         if (read_cmd_valid && read_cmd_ready) begin
            read_q.push_back(pack_expected(read_cmd));
            model_read_cmds <= model_read_cmds + 1;
         end
         if (write_cmd_valid && write_cmd_ready) begin
            write_q.push_back(pack_expected(write_cmd));
            model_write_cmds <= model_write_cmds + 1;
         end
         if (write_data_valid && dm_write_data_ready)
            model_write_stream <= add_beat(model_write_stream, write_data);
         if (dm_read_data_valid && read_data_ready)
            model_read_stream <= add_beat(model_read_stream, dm_read_data);
         if (dm_read_status_valid && read_status_ready)
            model_read_status <= add_status(model_read_status, dm_read_status);
         if (dm_write_status_valid && write_status_ready)
            model_write_status <= add_status(model_write_status, dm_write_status);
      end
      read_head     <= (read_q.size() != 0) ? read_q[0] : '0;
      write_head    <= (write_q.size() != 0) ? write_q[0] : '0;
      read_pending  <= read_q.size();
      write_pending <= write_q.size();
   end

   a_reset_state: assert property (@(posedge mem_clk) $rose(mem_aresetn) |->
      !dm_read_cmd_valid && !dm_write_cmd_valid && read_cmd_count == '0 &&
      write_cmd_count == '0 && read_stream_stats == '0 && write_stream_stats == '0 &&
      read_status_stats == '0 && write_status_stats == '0)
      else flag_failure("Reset left a command valid or a counter nonzero");

   // Command input has room when the entry is empty or draining
   a_read_ready: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      read_cmd_ready == (read_pending == 0 || dm_read_cmd_ready))
      else log_mismatch("read_cmd_ready", wide_t'($sampled(read_cmd_ready)),
                        wide_t'($sampled(read_pending) == 0 || $sampled(dm_read_cmd_ready)));
   a_write_ready: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      write_cmd_ready == (write_pending == 0 || dm_write_cmd_ready))
      else log_mismatch("write_cmd_ready", wide_t'($sampled(write_cmd_ready)),
                        wide_t'($sampled(write_pending) == 0 || $sampled(dm_write_cmd_ready)));

   a_read_accept: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      read_cmd_valid && read_cmd_ready |=> dm_read_cmd_valid)
      else flag_failure("Accepted read command did not reach the data mover next cycle");
   a_write_accept: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      write_cmd_valid && write_cmd_ready |=> dm_write_cmd_valid)
      else flag_failure("Accepted write command did not reach the data mover next cycle");
   a_read_stall: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      dm_read_cmd_valid && !dm_read_cmd_ready |=> dm_read_cmd_valid && $stable(dm_read_cmd))
      else flag_failure("dm_read_cmd changed or dropped while stalled");
   a_write_stall: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      dm_write_cmd_valid && !dm_write_cmd_ready |=> dm_write_cmd_valid && $stable(dm_write_cmd))
      else flag_failure("dm_write_cmd changed or dropped while stalled");
   a_read_word: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      dm_read_cmd_valid |-> read_pending != 0 && dm_read_cmd == read_head)
      else log_mismatch("dm_read_cmd", wide_t'($sampled(dm_read_cmd)),
                        wide_t'($sampled(read_head)));
   a_write_word: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      dm_write_cmd_valid |-> write_pending != 0 && dm_write_cmd == write_head)
      else log_mismatch("dm_write_cmd", wide_t'($sampled(dm_write_cmd)),
                        wide_t'($sampled(write_head)));
   a_read_kept: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      !dm_read_cmd_valid |-> read_pending == 0)
      else flag_failure("Accepted read command was lost before the data mover took it");
   a_write_kept: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      !dm_write_cmd_valid |-> write_pending == 0)
      else flag_failure("Accepted write command was lost before the data mover took it");

   a_read_count: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      read_cmd_count == model_read_cmds)
      else log_mismatch("read_cmd_count", wide_t'($sampled(read_cmd_count)),
                        wide_t'($sampled(model_read_cmds)));
   a_write_count: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      write_cmd_count == model_write_cmds)
      else log_mismatch("write_cmd_count", wide_t'($sampled(write_cmd_count)),
                        wide_t'($sampled(model_write_cmds)));
   a_read_stream: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      read_stream_stats == model_read_stream)
      else log_mismatch("read_stream_stats", wide_t'($sampled(read_stream_stats)),
                        wide_t'($sampled(model_read_stream)));
   a_write_stream: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      write_stream_stats == model_write_stream)
      else log_mismatch("write_stream_stats", wide_t'($sampled(write_stream_stats)),
                        wide_t'($sampled(model_write_stream)));
   a_read_status: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      read_status_stats == model_read_status)
      else log_mismatch("read_status_stats", wide_t'($sampled(read_status_stats)),
                        wide_t'($sampled(model_read_status)));
   a_write_status: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      write_status_stats == model_write_status)
      else log_mismatch("write_status_stats", wide_t'($sampled(write_status_stats)),
                        wide_t'($sampled(model_write_status)));

   // Pass-through paths as {beat or status, valid, ready}
   a_write_path: assert property (@(posedge mem_clk)
      {dm_write_data, dm_write_data_valid, write_data_ready} ==
      {write_data, write_data_valid, dm_write_data_ready})
      else log_mismatch("dm_write_data path",
         wide_t'($sampled({dm_write_data, dm_write_data_valid, write_data_ready})),
         wide_t'($sampled({write_data, write_data_valid, dm_write_data_ready})));
   a_read_path: assert property (@(posedge mem_clk)
      {read_data, read_data_valid, dm_read_data_ready} ==
      {dm_read_data, dm_read_data_valid, read_data_ready})
      else log_mismatch("read_data path",
         wide_t'($sampled({read_data, read_data_valid, dm_read_data_ready})),
         wide_t'($sampled({dm_read_data, dm_read_data_valid, read_data_ready})));
   a_read_status_path: assert property (@(posedge mem_clk)
      {read_status, read_status_valid, dm_read_status_ready} ==
      {dm_read_status, dm_read_status_valid, read_status_ready})
      else log_mismatch("read_status path",
         wide_t'($sampled({read_status, read_status_valid, dm_read_status_ready})),
         wide_t'($sampled({dm_read_status, dm_read_status_valid, read_status_ready})));
   a_write_status_path: assert property (@(posedge mem_clk)
      {write_status, write_status_valid, dm_write_status_ready} ==
      {dm_write_status, dm_write_status_valid, write_status_ready})
      else log_mismatch("write_status path",
         wide_t'($sampled({write_status, write_status_valid, dm_write_status_ready})),
         wide_t'($sampled({dm_write_status, dm_write_status_valid, write_status_ready})));

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired before both streams moved %0d beats", NUM_BEATS);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      logic [31:0] r;
      read_cmd              <= '0;
      read_cmd_valid        <= 1'b0;
      write_cmd             <= '0;
      write_cmd_valid       <= 1'b0;
      write_data            <= '0;
      write_data_valid      <= 1'b0;
      read_data_ready       <= 1'b0;
      read_status_ready     <= 1'b0;
      write_status_ready    <= 1'b0;
      dm_read_cmd_ready     <= 1'b0;
      dm_write_cmd_ready    <= 1'b0;
      dm_write_data_ready   <= 1'b0;
      dm_read_data          <= '0;
      dm_read_data_valid    <= 1'b0;
      dm_read_status        <= '0;
      dm_read_status_valid  <= 1'b0;
      dm_write_status       <= '0;
      dm_write_status_valid <= 1'b0;
      wait (mem_aresetn);
      while (read_beats < NUM_BEATS || write_beats < NUM_BEATS) begin
         @(posedge mem_clk);
         if (write_data_valid && write_data_ready) write_beats++;
         if (dm_read_data_valid && dm_read_data_ready) read_beats++;
         // A source moves on only when idle or just transferred
         if (!read_cmd_valid || read_cmd_ready) begin
            read_cmd_valid <= (next_random() & 3) != 0;
            read_cmd       <= random_cmd();
         end
         if (!write_cmd_valid || write_cmd_ready) begin
            write_cmd_valid <= (next_random() & 3) != 0;
            write_cmd       <= random_cmd();
         end
         if (!write_data_valid || write_data_ready) begin
            write_data_valid <= (next_random() & 3) != 0;
            write_data       <= random_beat();
         end
         if (!dm_read_data_valid || dm_read_data_ready) begin
            dm_read_data_valid <= (next_random() & 3) != 0;
            dm_read_data       <= random_beat();
         end
         if (!dm_read_status_valid || dm_read_status_ready) begin
            r = next_random();
            dm_read_status_valid <= r[9:8] != 2'd0;
            dm_read_status       <= r[7:0];              // Okay bit random too
         end
         if (!dm_write_status_valid || dm_write_status_ready) begin
            r = next_random();
            dm_write_status_valid <= r[9:8] != 2'd0;
            dm_write_status       <= r[7:0];
         end
         dm_read_cmd_ready   <= (next_random() & 1) != 0; // Frequent command stalls
         dm_write_cmd_ready  <= (next_random() & 1) != 0;
         dm_write_data_ready <= (next_random() & 3) != 0;
         read_data_ready     <= (next_random() & 3) != 0;
         read_status_ready   <= (next_random() & 3) != 0;
         write_status_ready  <= (next_random() & 3) != 0;
      end
      repeat (3) @(posedge mem_clk);                     // Let the last counts settle
      $display("Finished with %0d errors, write/read beats %0d/%0d, read/write cmds %0d/%0d",
               error_count, write_beats, read_beats, model_read_cmds, model_write_cmds);
      if (error_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
logic/mem_dm_pkg.sv
logic/mem_stats_pkg.sv
logic/mem_cmd_format.sv
logic/mem_beat_meter.sv
logic/mem_status_tracker.sv
logic/mem_channel_monitor.sv
tb/tb_clock_gen.sv
tb/tb_mem_channel_monitor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the channel front end testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module tb_mem_channel_monitor \
   -f vlog.f \
   -o tb_sim

# The log search below decides the outcome, also when the run exits early
./obj_dir/tb_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "RESULT: PASS" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi

echo "Simulation failed, see $LOG"
exit 1
